//--- include/snd_defs.svh
`ifndef SND_DEFS_SVH
`define SND_DEFS_SVH

// number of square channels, 1 to 4
`define SND_NUM_CH 2

// pwm counter width, period is 2**bits cycles
`define SND_PWM_BITS 8

// div bit whose falling edge clocks the length counters
`define SND_LEN_DIV_BIT 4

// global registers, channel c sits at 4c..4c+3
`define SND_ADR_PAN 6'h20
`define SND_ADR_VOL 6'h21
`define SND_ADR_PWR 6'h22

`endif

//--- src/snd_pkg.sv
`include "snd_defs.svh"

package snd_pkg;

	typedef logic [3:0] snd_sample_t;                  // per channel amplitude
	typedef logic [`SND_PWM_BITS-1:0] snd_level_t;     // mixed pwm level

	typedef enum logic [1:0] {
		SND_DUTY_12 = 2'd0,
		SND_DUTY_25 = 2'd1,
		SND_DUTY_50 = 2'd2,
		SND_DUTY_75 = 2'd3
	} snd_duty_t;

	typedef enum logic [1:0] {
		SND_REG_DUTY_LEN = 2'd0,
		SND_REG_ENV      = 2'd1,
		SND_REG_FREQ_LO  = 2'd2,
		SND_REG_CTRL     = 2'd3
	} snd_reg_sel_t;

	typedef struct packed {
		snd_duty_t  duty;
		logic [5:0] len_load;
	} snd_reg0_t;

	typedef struct packed {
		snd_sample_t init_vol;
		logic        env_up;
		logic [2:0]  env_per;
	} snd_reg1_t;

	typedef struct packed {
		logic       trigger;
		logic       len_en;
		logic [2:0] rsvd;
		logic [2:0] freq_hi;
	} snd_reg3_t;

endpackage

//--- src/snd_ch_if.sv
`timescale 1ns/1ps

interface snd_ch_if;
	import snd_pkg::*;

	logic         wr;        // one cycle write strobe
	snd_reg_sel_t sel;
	logic [7:0]   wdata;
	logic         tick_len;
	logic         tick_env;
	logic         power;
	logic         active;
	snd_sample_t  sample;

	modport ctrl (
		output wr, sel, wdata, tick_len, tick_env, power,
		input  active
	);

	modport chan (
		input  wr, sel, wdata, tick_len, tick_env, power,
		output active, sample
	);

	modport mix (
		input active, sample
	);

endinterface

//--- src/snd_regs.sv
`timescale 1ns/1ps
`include "snd_defs.svh"

module snd_regs (
	input  logic        gbclk,
	input  logic        reset,
	input  logic [5:0]  adr,
	input  logic [7:0]  din,
	input  logic        write,
	input  logic        read,       // reads have no side effects here
	input  logic [15:0] div,
	output logic [7:0]  dout,
	output logic [7:0]  pan,
	output logic [7:0]  master_vol,
	snd_ch_if.ctrl      ch [`SND_NUM_CH]
);
	import snd_pkg::*;

	logic                   power;
	logic [`SND_NUM_CH-1:0] act;
	logic                   tap_q;
	logic                   tap_fall;
	logic [1:0]             quarter;
	logic                   tick_len;
	logic                   tick_env;

	// global registers
	always_ff @(posedge gbclk) begin
		if (reset) begin
			power      <= 1'b0;
			pan        <= 8'h00;
			master_vol <= 8'h00;
		end else if (write && adr == `SND_ADR_PWR) begin
			power <= din[7];
			if (!din[7]) begin
				pan        <= 8'h00;
				master_vol <= 8'h00;
			end
		end else if (write && power) begin
			if (adr == `SND_ADR_PAN)
				pan <= din;
			if (adr == `SND_ADR_VOL)
				master_vol <= din;
		end
	end

	// frame sequencer on the div tap
	assign tap_fall = tap_q && !div[`SND_LEN_DIV_BIT];

	always_ff @(posedge gbclk) begin
		if (reset) begin
			tap_q    <= 1'b0;
			quarter  <= 2'd0;
			tick_len <= 1'b0;
			tick_env <= 1'b0;
		end else begin
			tap_q    <= div[`SND_LEN_DIV_BIT];
			tick_len <= tap_fall;
			tick_env <= tap_fall && quarter == 2'd3;
			if (!power)
				quarter <= 2'd0;    // envelope phase restarts at power on
			else if (tap_fall)
				quarter <= quarter + 2'd1;
		end
	end

	for (genvar c = 0; c < `SND_NUM_CH; c++) begin : gen_port
		// channel c owns adr 4c..4c+3
		always_ff @(posedge gbclk) begin
			if (reset)
				ch[c].wr <= 1'b0;
			else
				ch[c].wr <= write && power && adr[5:2] == 4'(c);
		end

		always_ff @(posedge gbclk) begin
			ch[c].sel   <= snd_reg_sel_t'(adr[1:0]);
			ch[c].wdata <= din;
		end

		assign ch[c].tick_len = tick_len;
		assign ch[c].tick_env = tick_env;
		assign ch[c].power    = power;
		assign act[c]         = ch[c].active;
	end

	// readback, channel registers read as ones
	always_comb begin
		case (adr)
			`SND_ADR_PAN: dout = pan;
			`SND_ADR_VOL: dout = master_vol;
			`SND_ADR_PWR: dout = {power, 7'(act)};
			default:      dout = 8'hff;
		endcase
	end

endmodule

//--- src/snd_square_ch.sv
`timescale 1ns/1ps

module snd_square_ch (
	input logic    gbclk,
	input logic    reset,
	snd_ch_if.chan ch
);
	import snd_pkg::*;

	// register fields
	snd_duty_t   duty;
	logic [5:0]  len_load;
	snd_sample_t init_vol;
	logic        env_up;
	logic [2:0]  env_per;
	logic [10:0] freq;
	logic        len_en;

	// running state
	logic        active;
	logic [6:0]  length;
	snd_sample_t vol;
	logic [2:0]  env_cnt;
	logic [2:0]  step;
	logic [10:0] timer;

	snd_reg0_t wr_r0;
	snd_reg1_t wr_r1;
	snd_reg3_t wr_r3;
	logic      trigger;
	logic [7:0] pattern;
	logic       duty_bit;

	assign wr_r0   = snd_reg0_t'(ch.wdata);
	assign wr_r1   = snd_reg1_t'(ch.wdata);
	assign wr_r3   = snd_reg3_t'(ch.wdata);
	assign trigger = ch.wr && ch.sel == SND_REG_CTRL && wr_r3.trigger;

	always_ff @(posedge gbclk) begin
		if (reset || !ch.power) begin
			duty     <= SND_DUTY_12;
			len_load <= 6'd0;
			init_vol <= 4'd0;
			env_up   <= 1'b0;
			env_per  <= 3'd0;
			freq     <= 11'd0;
			len_en   <= 1'b0;
		end else if (ch.wr) begin
			case (ch.sel)
				SND_REG_DUTY_LEN: begin
					duty     <= wr_r0.duty;
					len_load <= wr_r0.len_load;
				end
				SND_REG_ENV: begin
					init_vol <= wr_r1.init_vol;
					env_up   <= wr_r1.env_up;
					env_per  <= wr_r1.env_per;
				end
				SND_REG_FREQ_LO: freq[7:0] <= ch.wdata;
				SND_REG_CTRL: begin
					len_en     <= wr_r3.len_en;
					freq[10:8] <= wr_r3.freq_hi;
				end
			endcase
		end
	end

	always_ff @(posedge gbclk) begin
		if (reset || !ch.power) begin
			active  <= 1'b0;
			length  <= 7'd0;
			vol     <= 4'd0;
			env_cnt <= 3'd0;
			step    <= 3'd0;
			timer   <= 11'd0;
		end else if (trigger) begin
			active  <= 1'b1;
			length  <= 7'd64 - {1'b0, len_load};   // load of 0 gives 64
			vol     <= init_vol;
			env_cnt <= 3'd0;
			step    <= 3'd0;
			timer   <= 11'd0;
		end else begin
			// 2048 - freq cycles per step, last count is ~freq
			if (timer == ~freq) begin
				timer <= 11'd0;
				step  <= step + 3'd1;
			end else begin
				timer <= timer + 11'd1;
			end

			if (ch.tick_len && len_en && length != 7'd0) begin
				length <= length - 7'd1;
				if (length == 7'd1)
					active <= 1'b0;
			end

			if (ch.tick_env && env_per != 3'd0) begin   // period 0 holds volume
				if (env_cnt == env_per - 3'd1) begin
					env_cnt <= 3'd0;
					if (env_up && vol != 4'hf)
						vol <= vol + 4'd1;
					else if (!env_up && vol != 4'h0)
						vol <= vol - 4'd1;
				end else begin
					env_cnt <= env_cnt + 3'd1;
				end
			end
		end
	end

	// step 0 is the leftmost pattern bit
	always_comb begin
		case (duty)
			SND_DUTY_12: pattern = 8'b0000_0001;
			SND_DUTY_25: pattern = 8'b1000_0001;
			SND_DUTY_50: pattern = 8'b1000_0111;
			default:     pattern = 8'b0111_1110;
		endcase
		duty_bit = pattern[3'd7 - step];
	end

	assign ch.active = active;
	assign ch.sample = (active && duty_bit) ? vol : 4'd0;

endmodule

//--- src/snd_mixer.sv
`timescale 1ns/1ps
`include "snd_defs.svh"

module snd_mixer (
	input  logic       gbclk,
	input  logic       reset,
	input  logic [7:0] pan,
	input  logic [7:0] master_vol,
	snd_ch_if.mix      ch [`SND_NUM_CH],
	output logic       chl,
	output logic       chr,
	output logic       chm
);
	import snd_pkg::*;

	snd_sample_t              smp [`SND_NUM_CH];
	logic [7:0]               sum_l;
	logic [7:0]               sum_r;
	logic [10:0]              prod_l;
	logic [10:0]              prod_r;
	logic [`SND_PWM_BITS:0]   mono_sum;
	snd_level_t               next_l;
	snd_level_t               next_r;
	snd_level_t               next_m;
	snd_level_t               lvl_l;
	snd_level_t               lvl_r;
	snd_level_t               lvl_m;
	logic [`SND_PWM_BITS-1:0] pwm_cnt;

	for (genvar c = 0; c < `SND_NUM_CH; c++) begin : gen_smp
		assign smp[c] = ch[c].active ? ch[c].sample : 4'd0;
	end

	always_comb begin
		sum_l = 8'd0;
		sum_r = 8'd0;
		for (int i = 0; i < `SND_NUM_CH; i++) begin
			if (pan[4+i])
				sum_l = sum_l + 8'(smp[i]);
			if (pan[i])
				sum_r = sum_r + 8'(smp[i]);
		end

		// volume code 0..7 scales by 1..8
		prod_l   = 11'(sum_l) * 11'({1'b0, master_vol[6:4]} + 4'd1);
		prod_r   = 11'(sum_r) * 11'({1'b0, master_vol[2:0]} + 4'd1);
		next_l   = snd_level_t'(prod_l >> 3);
		next_r   = snd_level_t'(prod_r >> 3);
		mono_sum = {1'b0, next_l} + {1'b0, next_r};
		next_m   = snd_level_t'(mono_sum >> 1);
	end

	always_ff @(posedge gbclk) begin
		if (reset) begin
			pwm_cnt <= '0;
			lvl_l   <= '0;
			lvl_r   <= '0;
			lvl_m   <= '0;
		end else begin
			pwm_cnt <= pwm_cnt + 1'b1;
			if (&pwm_cnt) begin   // levels only change at wrap
				lvl_l <= next_l;
				lvl_r <= next_r;
				lvl_m <= next_m;
			end
		end
	end

	assign chl = pwm_cnt < lvl_l;
	assign chr = pwm_cnt < lvl_r;
	assign chm = pwm_cnt < lvl_m;

endmodule

//--- src/snd_top.sv
`timescale 1ns/1ps
`include "snd_defs.svh"

module snd_top (
	input  logic        gbclk,
	input  logic        reset,
	input  logic [5:0]  adr,
	input  logic [7:0]  din,
	output logic [7:0]  dout,
	input  logic        write,
	input  logic        read,
	input  logic [15:0] div,
	output logic        chl,
	output logic        chr,
	output logic        chm
);

	logic [7:0] pan;
	logic [7:0] master_vol;

	snd_ch_if ch_if [`SND_NUM_CH] ();

	snd_regs u_regs (
		.gbclk      (gbclk),
		.reset      (reset),
		.adr        (adr),
		.din        (din),
		.write      (write),
		.read       (read),
		.div        (div),
		.dout       (dout),
		.pan        (pan),
		.master_vol (master_vol),
		.ch         (ch_if)
	);

	for (genvar c = 0; c < `SND_NUM_CH; c++) begin : gen_ch
		snd_square_ch u_ch (
			.gbclk (gbclk),
			.reset (reset),
			.ch    (ch_if[c])
		);
	end

	snd_mixer u_mixer (
		.gbclk      (gbclk),
		.reset      (reset),
		.pan        (pan),
		.master_vol (master_vol),
		.ch         (ch_if),
		.chl        (chl),
		.chr        (chr),
		.chm        (chm)
	);

endmodule

//--- testbench/snd_sva.sv
`timescale 1ns/1ps

module snd_sva (
	input logic                gbclk,
	input logic                reset,
	input logic                power,
	input logic                active,
	input snd_pkg::snd_sample_t sample
);

	// a silent channel drives no amplitude
	sample_idle: assert property (@(posedge gbclk) disable iff (reset)
		!active |-> sample == 4'd0)
		else $error("sample is nonzero while the channel is inactive");

	power_drop: assert property (@(posedge gbclk) disable iff (reset)
		$fell(power) |=> !active)
		else $error("channel still active one cycle after power dropped");

endmodule

bind snd_square_ch snd_sva sva_i (
	.gbclk  (gbclk),
	.reset  (reset),
	.power  (ch.power),
	.active (active),
	.sample (ch.sample)
);

//--- testbench/snd_tb.sv
`timescale 1ns/1ps
`include "snd_defs.svh"

module snd_tb;
	import snd_pkg::*;

	// all test windows plus margin
	localparam int RUN_CYC = 10 + 700 + 64 * 32 + 5 * 256 + 4096 + 8 * 256 + 1000;

	logic        gbclk;
	logic        reset;
	logic [5:0]  adr;
	logic [7:0]  din;
	logic        write;
	logic        read;
	logic [15:0] div;
	logic [7:0]  dout;
	logic        chl;
	logic        chr;
	logic        chm;

	integer     seed;
	int         errors;
	int         tests_run;
	int         tests_failed;
	int         len_ticks;
	logic       tap_q;
	logic [7:0] pwm_phase;

	snd_top dut_i (
		.gbclk (gbclk),
		.reset (reset),
		.adr   (adr),
		.din   (din),
		.dout  (dout),
		.write (write),
		.read  (read),
		.div   (div),
		.chl   (chl),
		.chr   (chr),
		.chm   (chm)
	);

	always #4 gbclk = ~gbclk;

	always @(negedge gbclk)
		div <= div + 16'd1;   // free running timer divider

	// own count of div falls, and the pwm counter phase since reset
	always @(posedge gbclk) begin
		tap_q <= div[`SND_LEN_DIV_BIT];
		if (tap_q && !div[`SND_LEN_DIV_BIT])
			len_ticks <= len_ticks + 1;
		pwm_phase <= reset ? 8'd0 : pwm_phase + 8'd1;
	end

	// expected {left, right, mono} level for one set of channel samples
	function automatic logic [23:0] snd_ref_level(
		input logic [4*`SND_NUM_CH-1:0] vols,
		input logic [`SND_NUM_CH-1:0]   bits,
		input logic [7:0]               pan_v,
		input logic [7:0]               mv
	);
		int sum_l;
		int sum_r;
		int lv_l;
		int lv_r;
		sum_l = 0;
		sum_r = 0;
		for (int c = 0; c < `SND_NUM_CH; c++) begin
			if (bits[c] && pan_v[4+c])
				sum_l += vols[4*c +: 4];
			if (bits[c] && pan_v[c])
				sum_r += vols[4*c +: 4];
		end
		lv_l = (sum_l * (int'(mv[6:4]) + 1)) >> 3;
		lv_r = (sum_r * (int'(mv[2:0]) + 1)) >> 3;
		return {8'(lv_l), 8'(lv_r), 8'((lv_l + lv_r) >> 1)};
	endfunction

	function automatic logic duty_bit(input logic [1:0] code, input int k);
		logic [7:0] pat;
		case (code)
			2'd0:    pat = 8'b0000_0001;
			2'd1:    pat = 8'b1000_0001;
			2'd2:    pat = 8'b1000_0111;
			default: pat = 8'b0111_1110;
		endcase
		return pat[7-k];   // step 0 on the left
	endfunction

	task automatic check_value(input string name, input int got, input int exp);
		assert (got == exp) else begin
			errors++;
			$display("[FAIL] %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic bus_write(input logic [5:0] a, input logic [7:0] d);
		@(negedge gbclk);
		adr   = a;
		din   = d;
		write = 1'b1;
		@(negedge gbclk);
		write = 1'b0;
	endtask

	task automatic bus_read(input logic [5:0] a, output logic [7:0] d);
		@(negedge gbclk);
		adr  = a;
		read = 1'b1;
		@(negedge gbclk);
		d    = dout;
		read = 1'b0;
	endtask

	task automatic count_high(input int n, output int hl, output int hr, output int hm);
		hl = 0;
		hr = 0;
		hm = 0;
		repeat (n) begin
			hl += chl;
			hr += chr;
			hm += chm;
			@(negedge gbclk);
		end
	endtask

	task automatic end_test(input string name, input int err0);
		tests_run++;
		if (errors == err0) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: %0d errors", tests_run, name, errors - err0);
		end
	endtask

	initial begin
		repeat (RUN_CYC) @(posedge gbclk);
		$display("watchdog expired after %0d cycles, tests did not finish", RUN_CYC);
		$display("Verification failed");
		$finish;
	end

	initial begin
		logic [7:0]               rd;
		logic [7:0]               pan_v;
		logic [7:0]               mv;
		logic [4*`SND_NUM_CH-1:0] vols;
		logic [2*`SND_NUM_CH-1:0] duties;
		logic [`SND_NUM_CH-1:0]   bits;
		logic [23:0]              lv;
		int                       hl;
		int                       hr;
		int                       hm;
		int                       el;
		int                       er;
		int                       em;
		int                       err0;
		int                       len_l;
		int                       t0;
		int                       cyc;
		int                       v;

		seed         = 96858;
		gbclk        = 1'b0;
		reset        = 1'b1;
		adr          = 6'd0;
		din          = 8'd0;
		write        = 1'b0;
		read         = 1'b0;
		div          = 16'd0;
		tap_q        = 1'b0;
		len_ticks    = 0;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		repeat (10) @(negedge gbclk);
		reset = 1'b0;

		err0 = errors;
		bus_read(`SND_ADR_PWR, rd);
		check_value("dout (pwr)", rd, 8'h00);
		count_high(512, hl, hr, hm);
		check_value("chl high count", hl, 0);
		check_value("chr high count", hr, 0);
		check_value("chm high count", hm, 0);
		bus_write(`SND_ADR_PAN, 8'h5a);   // ignored, power is off
		bus_read(`SND_ADR_PAN, rd);
		check_value("dout (pan)", rd, 8'h00);
		end_test("reset state", err0);

		err0 = errors;
		bus_write(`SND_ADR_PWR, 8'h80);
		pan_v = $random(seed);
		mv    = $random(seed);
		bus_write(`SND_ADR_PAN, pan_v);
		bus_write(`SND_ADR_VOL, mv);
		bus_read(`SND_ADR_PAN, rd);
		check_value("dout (pan)", rd, pan_v);
		bus_read(`SND_ADR_VOL, rd);
		check_value("dout (vol)", rd, mv);
		bus_write(`SND_ADR_PWR, 8'h00);
		bus_read(`SND_ADR_PAN, rd);
		check_value("dout (pan)", rd, 8'h00);
		bus_read(`SND_ADR_VOL, rd);
		check_value("dout (vol)", rd, 8'h00);
		end_test("register readback", err0);

		err0 = errors;
		bus_write(`SND_ADR_PWR, 8'h80);
		len_l = {$random(seed)} % 60;
		bus_write(6'd0, {2'd2, 6'(len_l)});
		bus_write(6'd1, 8'hf0);
		bus_write(6'd3, 8'hc0);   // trigger with length enable
		t0 = len_ticks;
		bus_read(`SND_ADR_PWR, rd);
		check_value("dout (pwr)", rd, 8'h81);
		cyc = 0;
		while (dout[0] && cyc < 64 * 32 + 100) begin
			@(negedge gbclk);
			cyc++;
		end
		assert (!dout[0]) else begin
			errors++;
			$display("length counter never cleared the active bit of channel 0");
		end
		v = len_ticks - t0;
		assert (dout[0] || (v >= 63 - len_l && v <= 65 - len_l)) else begin
			errors++;
			$display("[FAIL] length ticks got %h expected %h", v, 64 - len_l);
		end
		end_test("length counter", err0);

		err0 = errors;
		bus_write(`SND_ADR_PWR, 8'h00);
		bus_write(`SND_ADR_PWR, 8'h80);
		pan_v  = $random(seed);
		mv     = $random(seed);
		vols   = $random(seed);
		duties = $random(seed);
		bus_write(`SND_ADR_PAN, pan_v);
		bus_write(`SND_ADR_VOL, mv);
		for (int c = 0; c < `SND_NUM_CH; c++) begin
			bus_write(6'(4 * c), {duties[2*c +: 2], 6'd0});
			bus_write(6'(4 * c + 1), {vols[4*c +: 4], 4'h0});   // period 0 holds volume
			bus_write(6'(4 * c + 2), 8'h00);
		end
		// trigger well before a wrap so every channel steps between wraps
		while (pwm_phase != 8'd60)
			@(negedge gbclk);
		for (int c = 0; c < `SND_NUM_CH; c++)
			bus_write(6'(4 * c + 3), 8'h86);   // freq 0x600, 512 cycles per step
		repeat (512) @(negedge gbclk);
		count_high(4096, hl, hr, hm);
		el = 0;
		er = 0;
		em = 0;
		for (int k = 0; k < 8; k++) begin
			for (int c = 0; c < `SND_NUM_CH; c++)
				bits[c] = duty_bit(duties[2*c +: 2], k);
			lv = snd_ref_level(vols, bits, pan_v, mv);
			el += 2 * lv[23:16];
			er += 2 * lv[15:8];
			em += 2 * lv[7:0];
		end
		check_value("chl high count", hl, el);
		check_value("chr high count", hr, er);
		check_value("chm high count", hm, em);
		end_test("duty and mixing", err0);

		err0 = errors;
		bus_write(`SND_ADR_PWR, 8'h00);
		bus_write(`SND_ADR_PWR, 8'h80);
		bus_write(`SND_ADR_PAN, 8'h10);   // channel 0 left only
		bus_write(`SND_ADR_VOL, 8'h70);
		bus_write(6'd0, 8'h40);   // 25 %, step 0 high
		bus_write(6'd1, 8'hf1);
		bus_write(6'd2, 8'h00);
		bus_write(6'd3, 8'h80);   // freq 0 holds step 0 for 2048 cycles
		repeat (2) @(negedge gbclk);
		while (pwm_phase != 8'd0)
			@(negedge gbclk);
		bits    = '0;
		bits[0] = 1'b1;
		v       = -1;
		for (int p = 0; p < 6; p++) begin
			count_high(256, hl, hr, hm);
			if (p == 0) begin
				// at most three envelope ticks before the first wrap
				for (int i = 12; i <= 15; i++) begin
					vols = 4'(i);
					lv   = snd_ref_level(vols, bits, 8'h10, 8'h70);
					if (hl == int'(lv[23:16]))
						v = i;
				end
				assert (v >= 0) else begin
					errors++;
					$display("[FAIL] chl first envelope level got %h expected 0c to 0f", hl);
				end
			end else begin
				v    = (v > 2) ? v - 2 : 0;   // two envelope ticks per pwm period
				vols = 4'(v);
				lv   = snd_ref_level(vols, bits, 8'h10, 8'h70);
				check_value("chl envelope level", hl, lv[23:16]);
			end
		end
		end_test("envelope", err0);

		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

//--- src.f
+incdir+include
src/snd_pkg.sv
src/snd_ch_if.sv
src/snd_regs.sv
src/snd_square_ch.sv
src/snd_mixer.sv
src/snd_top.sv
testbench/snd_sva.sv
testbench/snd_tb.sv
